//--- sources.f
+incdir+sim
hdl/llc_pkg.sv
hdl/llc_pipe_reg.sv
hdl/llc_input_decoder.sv
hdl/llc_set_table.sv
hdl/llc_localmem.sv
hdl/llc_lookup_way.sv
hdl/llc_process_request.sv
hdl/llc_core.sv
sim/llc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cache core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module llc_tb -f sources.f -o llc_sim

./obj_dir/llc_sim | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- sim/llc_ref_model.svh
// cache reference model
`ifndef LLC_REF_MODEL_SVH
`define LLC_REF_MODEL_SVH

// newest data per line address, as the requester sees it
llc_pkg::line_t        shadow [llc_pkg::line_addr_t];
bit                    cache_valid [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
bit                    cache_dirty [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
llc_pkg::llc_tag_t     cache_tag   [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
int                    evict_ptr   [llc_pkg::LLC_SETS];
llc_pkg::llc_rsp_t     exp_rsp [$];
llc_pkg::llc_mem_req_t exp_mem [$];

// initial memory contents, built from the whole line address
function automatic llc_pkg::line_t init_line(llc_pkg::line_addr_t a);
    return {a, a ^ 16'hc3a5, ~a, a + 16'h1d2f};
endfunction

function automatic llc_pkg::line_t line_value(llc_pkg::line_addr_t a);
    if (shadow.exists(a)) begin
        return shadow[a];
    end
    return init_line(a);
endfunction

function automatic void clear_model();
    for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
        evict_ptr[s] = 0;
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            cache_valid[s][w] = 1'b0;
            cache_dirty[s][w] = 1'b0;
            cache_tag[s][w]   = '0;
        end
    end
    shadow.delete();
    exp_rsp.delete();
    exp_mem.delete();
endfunction

// one request in order; queues the expected memory traffic and response
function automatic bit predict_access(logic wr, llc_pkg::line_addr_t addr,
                                      llc_pkg::line_t data);
    llc_pkg::llc_set_t     s;
    llc_pkg::llc_tag_t     t;
    llc_pkg::llc_mem_req_t mreq;
    llc_pkg::llc_rsp_t     rsp;
    int                    way;
    bit                    hit;
    bit                    found;
    s     = addr[llc_pkg::LLC_SET_BITS-1:0];
    t     = addr[llc_pkg::LINE_ADDR_BITS-1:llc_pkg::LLC_SET_BITS];
    way   = 0;
    hit   = 1'b0;
    found = 1'b0;
    for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
        if (cache_valid[s][w] && cache_tag[s][w] == t) begin
            hit = 1'b1;
            way = w;
        end
    end
    if (!hit) begin
        // lowest free way, else round robin over a full set
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (!cache_valid[s][w] && !found) begin
                found = 1'b1;
                way   = w;
            end
        end
        if (!found) begin
            way          = evict_ptr[s];
            evict_ptr[s] = (evict_ptr[s] + 1) % llc_pkg::LLC_WAYS;
        end
        if (cache_valid[s][way] && cache_dirty[s][way]) begin
            mreq.wr   = 1'b1;
            mreq.addr = {cache_tag[s][way], s};
            mreq.data = line_value(mreq.addr);
            exp_mem.push_back(mreq);
        end
        mreq.wr   = 1'b0;
        mreq.addr = addr;
        mreq.data = '0;
        exp_mem.push_back(mreq);
        cache_valid[s][way] = 1'b1;
        cache_tag[s][way]   = t;
        cache_dirty[s][way] = 1'b0;
    end
    if (wr) begin
        shadow[addr]        = data;
        cache_dirty[s][way] = 1'b1;
    end
    rsp.addr = addr;
    rsp.data = line_value(addr);
    exp_rsp.push_back(rsp);
    return hit;
endfunction

`endif

//--- sim/llc_tb.sv
// cache core testbench
`timescale 1ns/1ps

module llc_tb;

    localparam int NUM_REQS   = 400;
    localparam int MAX_CYCLES = NUM_REQS * 40;

    logic                  clk;
    logic                  rst;
    llc_pkg::llc_req_t     req_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    llc_pkg::llc_rsp_t     rsp_o;
    logic                  rsp_valid_o;
    logic                  rsp_ready_i;
    llc_pkg::llc_mem_req_t mem_req_o;
    logic                  mem_req_valid_o;
    logic                  mem_req_ready_i;
    llc_pkg::line_t        mem_rsp_i;
    logic                  mem_rsp_valid_i;
    logic                  mem_rsp_ready_o;

    int                  value_errors;
    int                  other_errors;
    int                  cycles;
    int                  issued;
    int                  rsp_count;
    int                  hits;
    int                  gap;
    int                  fill_wait;
    bit                  req_taken;
    bit                  mem_rsp_taken;
    bit                  fill_start;
    bit                  fill_pending;
    llc_pkg::line_addr_t fill_addr;
    llc_pkg::line_t      flat_mem [llc_pkg::line_addr_t];

    `include "llc_ref_model.svh"

    llc_core dut_i (
        .clk             (clk),
        .rst             (rst),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 8 odd sets with 6 tags each
    function automatic llc_pkg::line_addr_t pool_addr(int idx);
        llc_pkg::llc_set_t s;
        llc_pkg::llc_tag_t t;
        s = llc_pkg::llc_set_t'((idx % 8) * 2 + 1);
        t = llc_pkg::llc_tag_t'(12'h040 + (idx / 8) * 12'h111);
        return {t, s};
    endfunction

    function automatic llc_pkg::line_t mem_read(llc_pkg::line_addr_t a);
        if (flat_mem.exists(a)) begin
            return flat_mem[a];
        end
        return init_line(a);
    endfunction

    // one cycle of stimulus, called just after the rising edge
    task automatic drive_cycle();
        int idx;
        rsp_ready_i     = ($urandom_range(0, 99) >= 20);
        mem_req_ready_i = ($urandom_range(0, 99) >= 20);
        if (req_taken) begin
            req_valid_i = 1'b0;
            gap         = int'($urandom_range(0, 3));
        end
        if (!req_valid_i && issued < NUM_REQS) begin
            if (gap > 0) begin
                gap--;
            end else begin
                idx         = int'($urandom_range(0, 47));
                req_i.wr    = ($urandom_range(0, 99) < 40);
                req_i.addr  = pool_addr(idx);
                req_i.data  = {$urandom, $urandom};
                req_valid_i = 1'b1;
                issued++;
            end
        end
        // memory responder, 1 to 6 cycles per fill
        if (mem_rsp_taken) begin
            mem_rsp_valid_i = 1'b0;
        end
        if (fill_start) begin
            fill_start   = 1'b0;
            fill_pending = 1'b1;
            fill_wait    = int'($urandom_range(0, 5));
        end
        if (fill_pending && !mem_rsp_valid_i) begin
            if (fill_wait > 0) begin
                fill_wait--;
            end else begin
                mem_rsp_i       = mem_read(fill_addr);
                mem_rsp_valid_i = 1'b1;
                fill_pending    = 1'b0;
            end
        end
    endtask

    task automatic check_response();
        llc_pkg::llc_rsp_t want;
        rsp_count++;
        assert (exp_rsp.size() > 0) else begin
            other_errors++;
            $display("response at %0t with no request outstanding", $time);
        end
        if (exp_rsp.size() > 0) begin
            want = exp_rsp.pop_front();
            assert (rsp_o.addr == want.addr) else begin
                value_errors++;
                $display("[FAIL] %0t: response address %h, expected %h",
                         $time, rsp_o.addr, want.addr);
            end
            assert (rsp_o.data == want.data) else begin
                value_errors++;
                $display("[FAIL] %0t: response data for %h is %h, expected %h",
                         $time, want.addr, rsp_o.data, want.data);
            end
        end
    endtask

    task automatic check_mem_request();
        llc_pkg::llc_mem_req_t want;
        assert (exp_mem.size() > 0) else begin
            other_errors++;
            $display("memory request to %h at %0t that no miss calls for",
                     mem_req_o.addr, $time);
        end
        if (exp_mem.size() > 0) begin
            want = exp_mem.pop_front();
            assert (mem_req_o.wr == want.wr && mem_req_o.addr == want.addr) else begin
                value_errors++;
                $display("[FAIL] %0t: memory request wr=%b addr=%h, expected wr=%b addr=%h",
                         $time, mem_req_o.wr, mem_req_o.addr, want.wr, want.addr);
            end
            if (want.wr) begin
                assert (mem_req_o.data == want.data) else begin
                    value_errors++;
                    $display("[FAIL] %0t: write-back data for %h is %h, expected %h",
                             $time, want.addr, mem_req_o.data, want.data);
                end
            end
        end
        if (mem_req_o.wr) begin
            flat_mem[mem_req_o.addr] = mem_req_o.data;
        end else begin
            fill_start = 1'b1;
            fill_addr  = mem_req_o.addr;
        end
    endtask

    // everything is stable here, so these are the transfers of the next edge
    always @(negedge clk) begin
        cycles++;
        req_taken     = req_valid_i && req_ready_o;
        mem_rsp_taken = mem_rsp_valid_i && mem_rsp_ready_o;
        if (req_taken) begin
            if (predict_access(req_i.wr, req_i.addr, req_i.data)) begin
                hits++;
            end
        end
        if (rsp_valid_o && rsp_ready_i) begin
            check_response();
        end
        if (mem_req_valid_o && mem_req_ready_i) begin
            check_mem_request();
        end
    end

    initial begin
        void'($urandom(37672));
        rst             = 1'b0;
        req_i           = '0;
        req_valid_i     = 1'b0;
        rsp_ready_i     = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_i       = '0;
        mem_rsp_valid_i = 1'b0;
        value_errors    = 0;
        other_errors    = 0;
        cycles          = 0;
        issued          = 0;
        rsp_count       = 0;
        hits            = 0;
        gap             = 0;
        fill_wait       = 0;
        req_taken       = 1'b0;
        mem_rsp_taken   = 1'b0;
        fill_start      = 1'b0;
        fill_pending    = 1'b0;
        fill_addr       = '0;
        clear_model();

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        assert (!rsp_valid_o && !mem_req_valid_o) else begin
            other_errors++;
            $display("response or memory request valid directly after reset");
        end
        // nothing asked for yet, so both ready outputs stay low
        assert (!req_ready_o && !mem_rsp_ready_o) else begin
            other_errors++;
            $display("request or memory response ready high directly after reset");
        end

        while (rsp_count < NUM_REQS && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end

        if (cycles >= MAX_CYCLES) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycles, rsp_count, NUM_REQS);
        end else begin
            // idle a little to catch stray traffic
            repeat (10) begin
                @(posedge clk);
                #1;
                drive_cycle();
            end
            assert (exp_mem.size() == 0) else begin
                other_errors++;
                $display("%0d expected memory requests never issued", exp_mem.size());
            end
            assert (exp_rsp.size() == 0) else begin
                other_errors++;
                $display("%0d expected responses never seen", exp_rsp.size());
            end
        end

        $display("%0d responses, %0d hits, %0d value errors, %0d other errors",
                 rsp_count, hits, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/llc_core.sv
// last-level cache core
`timescale 1ns/1ps

module llc_core (
    input  logic                  clk,
    input  logic                  rst,
    input  llc_pkg::llc_req_t     req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output llc_pkg::llc_rsp_t     rsp_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output llc_pkg::llc_mem_req_t mem_req_o,
    output logic                  mem_req_valid_o,
    input  logic                  mem_req_ready_i,
    input  llc_pkg::line_t        mem_rsp_i,
    input  logic                  mem_rsp_valid_i,
    output logic                  mem_rsp_ready_o
);

    llc_pkg::llc_decoded_t dec_data;
    logic                  dec_valid;
    logic                  dec_ready;
    logic                  set_busy;
    logic                  table_full;
    logic                  add;
    llc_pkg::llc_set_t     add_set;
    logic                  remove;
    llc_pkg::llc_set_t     remove_set;

    llc_pkg::llc_decoded_t dm_data;
    logic                  dm_valid;
    logic                  dm_ready;
    llc_pkg::llc_decoded_t ml_data;
    logic                  ml_valid;
    logic                  ml_ready;

    logic                                       rd_en;
    llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] rd_entries;
    llc_pkg::llc_way_t                          rd_evict_way;
    llc_pkg::llc_read_pkt_t                     rd_pkt;
    llc_pkg::llc_lookup_pkt_t                   lookup_pkt;
    llc_pkg::llc_lookup_pkt_t                   item;
    logic                                       item_valid;
    logic                                       item_ready;
    llc_pkg::llc_wr_t                           wr;

    // set is read on the edge that moves the request into pr_mem_lookup
    assign rd_en = dm_valid && dm_ready;

    assign rd_pkt.dec       = ml_data;
    assign rd_pkt.entries   = rd_entries;
    assign rd_pkt.evict_way = rd_evict_way;

    llc_input_decoder u_input_decoder (
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .dec_o        (dec_data),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (dec_ready),
        .set_busy_i   (set_busy),
        .table_full_i (table_full),
        .add_o        (add),
        .add_set_o    (add_set)
    );

    llc_set_table u_set_table (
        .clk          (clk),
        .rst          (rst),
        .add_i        (add),
        .add_set_i    (add_set),
        .query_set_i  (dec_data.set),
        .remove_i     (remove),
        .remove_set_i (remove_set),
        .set_busy_o   (set_busy),
        .table_full_o (table_full)
    );

    llc_pipe_reg #(.pkt_t(llc_pkg::llc_decoded_t)) pr_dec_mem (
        .clk     (clk),
        .rst     (rst),
        .valid_i (dec_valid),
        .ready_o (dec_ready),
        .data_i  (dec_data),
        .valid_o (dm_valid),
        .ready_i (dm_ready),
        .data_o  (dm_data)
    );

    llc_pipe_reg #(.pkt_t(llc_pkg::llc_decoded_t)) pr_mem_lookup (
        .clk     (clk),
        .rst     (rst),
        .valid_i (dm_valid),
        .ready_o (dm_ready),
        .data_i  (dm_data),
        .valid_o (ml_valid),
        .ready_i (ml_ready),
        .data_o  (ml_data)
    );

    llc_localmem u_localmem (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .rd_set_i       (dm_data.set),
        .rd_entries_o   (rd_entries),
        .rd_evict_way_o (rd_evict_way),
        .wr_i           (wr)
    );

    llc_lookup_way u_lookup_way (
        .rd_pkt_i     (rd_pkt),
        .lookup_pkt_o (lookup_pkt)
    );

    llc_pipe_reg #(.pkt_t(llc_pkg::llc_lookup_pkt_t)) pr_lookup_proc (
        .clk     (clk),
        .rst     (rst),
        .valid_i (ml_valid),
        .ready_o (ml_ready),
        .data_i  (lookup_pkt),
        .valid_o (item_valid),
        .ready_i (item_ready),
        .data_o  (item)
    );

    llc_process_request u_process_request (
        .clk             (clk),
        .rst             (rst),
        .item_i          (item),
        .item_valid_i    (item_valid),
        .item_ready_o    (item_ready),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .wr_o            (wr),
        .remove_o        (remove),
        .remove_set_o    (remove_set)
    );

endmodule

//--- hdl/llc_process_request.sv
// request processing and local memory update
`timescale 1ns/1ps

module llc_process_request (
    input  logic                     clk,
    input  logic                     rst,
    input  llc_pkg::llc_lookup_pkt_t item_i,
    input  logic                     item_valid_i,
    output logic                     item_ready_o,
    output llc_pkg::llc_rsp_t        rsp_o,
    output logic                     rsp_valid_o,
    input  logic                     rsp_ready_i,
    output llc_pkg::llc_mem_req_t    mem_req_o,
    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    input  llc_pkg::line_t           mem_rsp_i,
    input  logic                     mem_rsp_valid_i,
    output logic                     mem_rsp_ready_o,
    output llc_pkg::llc_wr_t         wr_o,
    output logic                     remove_o,
    output llc_pkg::llc_set_t        remove_set_o
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE_BACK,
        FETCH,
        WAIT_FILL,
        RESPOND
    } state_t;

    state_t         state_q;
    state_t         state_d;
    llc_pkg::line_t fill_q;
    llc_pkg::line_t new_line;
    logic           victim_dirty;
    logic           done;

    assign victim_dirty = item_i.entry.valid && item_i.entry.dirty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (item_valid_i) begin
                    if (item_i.hit) begin
                        state_d = RESPOND;
                    end else if (victim_dirty) begin
                        state_d = WRITE_BACK;
                    end else begin
                        state_d = FETCH;
                    end
                end
            end
            WRITE_BACK: begin
                if (mem_req_ready_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (mem_req_ready_i) begin
                    state_d = WAIT_FILL;
                end
            end
            WAIT_FILL: begin
                if (mem_rsp_valid_i) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == WAIT_FILL && mem_rsp_valid_i) begin
            fill_q <= mem_rsp_i;
        end
    end

    // write data wins, then the cached line, then the fetched one
    assign new_line = item_i.dec.req.wr ? item_i.dec.req.data :
                      (item_i.hit ? item_i.entry.line : fill_q);

    // memory side, victim address rebuilt from its tag and our set
    assign mem_req_valid_o = (state_q == WRITE_BACK) || (state_q == FETCH);
    assign mem_req_o.wr    = (state_q == WRITE_BACK);
    assign mem_req_o.addr  = (state_q == WRITE_BACK) ?
                             {item_i.entry.tag, item_i.dec.set} : item_i.dec.req.addr;
    assign mem_req_o.data  = (state_q == WRITE_BACK) ? item_i.entry.line : '0;
    assign mem_rsp_ready_o = (state_q == WAIT_FILL);

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_o.addr  = item_i.dec.req.addr;
    assign rsp_o.data  = new_line;

    // item retires on the response transfer
    assign done         = rsp_valid_o && rsp_ready_i;
    assign item_ready_o = done;
    assign remove_o     = done;
    assign remove_set_o = item_i.dec.set;

    assign wr_o.en          = done;
    assign wr_o.set         = item_i.dec.set;
    assign wr_o.way         = item_i.way;
    assign wr_o.entry.valid = 1'b1;
    assign wr_o.entry.dirty = item_i.dec.req.wr || (item_i.hit && item_i.entry.dirty);
    assign wr_o.entry.tag   = item_i.dec.tag;
    assign wr_o.entry.line  = new_line;
    assign wr_o.evict_way   = item_i.next_evict_way;

endmodule

//--- hdl/llc_lookup_way.sv
// way lookup and victim choice
`timescale 1ns/1ps

module llc_lookup_way (
    input  llc_pkg::llc_read_pkt_t   rd_pkt_i,
    output llc_pkg::llc_lookup_pkt_t lookup_pkt_o
);

    logic              hit;
    logic              free_found;
    llc_pkg::llc_way_t hit_way;
    llc_pkg::llc_way_t free_way;
    llc_pkg::llc_way_t way;

    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        free_found = 1'b0;
        free_way   = '0;
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (rd_pkt_i.entries[w].valid && rd_pkt_i.entries[w].tag == rd_pkt_i.dec.tag) begin
                hit     = 1'b1;
                hit_way = llc_pkg::llc_way_t'(w);
            end
            // first invalid way from the bottom
            if (!rd_pkt_i.entries[w].valid && !free_found) begin
                free_found = 1'b1;
                free_way   = llc_pkg::llc_way_t'(w);
            end
        end
    end

    // full set on a miss falls back to the round-robin pointer
    assign way = hit ? hit_way : (free_found ? free_way : rd_pkt_i.evict_way);

    assign lookup_pkt_o.dec   = rd_pkt_i.dec;
    assign lookup_pkt_o.hit   = hit;
    assign lookup_pkt_o.way   = way;
    assign lookup_pkt_o.entry = rd_pkt_i.entries[way];

    // pointer only moves when a valid line gets evicted
    assign lookup_pkt_o.next_evict_way = (!hit && !free_found) ?
        rd_pkt_i.evict_way + llc_pkg::llc_way_t'(1) : rd_pkt_i.evict_way;

endmodule

//--- hdl/llc_localmem.sv
// tag, state and line storage
`timescale 1ns/1ps

module llc_localmem (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       rd_en_i,
    input  llc_pkg::llc_set_t                          rd_set_i,
    output llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] rd_entries_o,
    output llc_pkg::llc_way_t                          rd_evict_way_o,
    input  llc_pkg::llc_wr_t                           wr_i
);

    // valid bits and eviction pointers
    logic [llc_pkg::LLC_WAYS-1:0] valid_q [llc_pkg::LLC_SETS];
    llc_pkg::llc_way_t            evict_q [llc_pkg::LLC_SETS];

    // payload arrays
    logic              dirty_mem [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_tag_t tag_mem   [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::line_t    line_mem  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
                valid_q[s] <= '0;
                evict_q[s] <= '0;
            end
        end else if (wr_i.en) begin
            valid_q[wr_i.set][wr_i.way] <= wr_i.entry.valid;
            evict_q[wr_i.set]           <= wr_i.evict_way;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            dirty_mem[wr_i.set][wr_i.way] <= wr_i.entry.dirty;
            tag_mem[wr_i.set][wr_i.way]   <= wr_i.entry.tag;
            line_mem[wr_i.set][wr_i.way]  <= wr_i.entry.line;
        end
    end

    // registered read of the whole set
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                rd_entries_o[w].valid <= valid_q[rd_set_i][w];
                rd_entries_o[w].dirty <= dirty_mem[rd_set_i][w];
                rd_entries_o[w].tag   <= tag_mem[rd_set_i][w];
                rd_entries_o[w].line  <= line_mem[rd_set_i][w];
            end
            rd_evict_way_o <= evict_q[rd_set_i];
        end
    end

endmodule

//--- hdl/llc_set_table.sv
// table of sets in flight
`timescale 1ns/1ps

module llc_set_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              add_i,
    input  llc_pkg::llc_set_t add_set_i,
    input  llc_pkg::llc_set_t query_set_i,
    input  logic              remove_i,
    input  llc_pkg::llc_set_t remove_set_i,
    output logic              set_busy_o,
    output logic              table_full_o
);

    logic [llc_pkg::LLC_SET_TABLE_ENTRIES-1:0] valid_q;
    llc_pkg::llc_set_t                         set_q [llc_pkg::LLC_SET_TABLE_ENTRIES];
    logic [$clog2(llc_pkg::LLC_SET_TABLE_ENTRIES)-1:0] free_idx;

    always_comb begin
        set_busy_o = 1'b0;
        free_idx   = '0;
        for (int i = llc_pkg::LLC_SET_TABLE_ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && set_q[i] == query_set_i) begin
                set_busy_o = 1'b1;
            end
            // lowest free entry wins
            if (!valid_q[i]) begin
                free_idx = i[$clog2(llc_pkg::LLC_SET_TABLE_ENTRIES)-1:0];
            end
        end
    end

    assign table_full_o = &valid_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < llc_pkg::LLC_SET_TABLE_ENTRIES; i++) begin
                if (remove_i && valid_q[i] && set_q[i] == remove_set_i) begin
                    valid_q[i] <= 1'b0;
                end
            end
            if (add_i) begin
                valid_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (add_i) begin
            set_q[free_idx] <= add_set_i;
        end
    end

endmodule

//--- hdl/llc_input_decoder.sv
// request decoder
`timescale 1ns/1ps

module llc_input_decoder (
    input  llc_pkg::llc_req_t     req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output llc_pkg::llc_decoded_t dec_o,
    output logic                  dec_valid_o,
    input  logic                  dec_ready_i,
    input  logic                  set_busy_i,
    input  logic                  table_full_i,
    output logic                  add_o,
    output llc_pkg::llc_set_t     add_set_o
);

    logic set_free;

    // address breakdown, set in the low bits
    assign dec_o.req = req_i;
    assign dec_o.set = req_i.addr[llc_pkg::LLC_SET_BITS-1:0];
    assign dec_o.tag = req_i.addr[llc_pkg::LINE_ADDR_BITS-1 -: llc_pkg::LLC_TAG_BITS];

    // a set already in flight holds the request here
    assign set_free = !set_busy_i && !table_full_i;

    assign dec_valid_o = req_valid_i && set_free;
    assign req_ready_o = dec_valid_o && dec_ready_i;

    // ready already includes valid, so this is the accept strobe
    assign add_o     = req_ready_o;
    assign add_set_o = dec_o.set;

endmodule

//--- hdl/llc_pipe_reg.sv
// valid/ready pipeline register
`timescale 1ns/1ps

module llc_pipe_reg #(
    parameter type pkt_t = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    output logic ready_o,
    input  pkt_t data_i,
    output logic valid_o,
    input  logic ready_i,
    output pkt_t data_o
);

    // can load when empty or when the held item leaves this cycle
    assign ready_o = !valid_o || ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_o <= data_i;
        end
    end

endmodule

//--- hdl/llc_pkg.sv
// last-level cache shared types
package llc_pkg;

    // cache geometry
    localparam int LLC_WAYS              = 4;
    localparam int LLC_SETS              = 16;
    localparam int LLC_SET_BITS          = 4;
    localparam int LLC_TAG_BITS          = 12;
    localparam int LINE_ADDR_BITS        = 16;
    localparam int LINE_BITS             = 64;
    localparam int LLC_SET_TABLE_ENTRIES = 4;

    typedef logic [LINE_ADDR_BITS-1:0]    line_addr_t;
    typedef logic [LLC_SET_BITS-1:0]      llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0]      llc_tag_t;
    typedef logic [$clog2(LLC_WAYS)-1:0]  llc_way_t;
    typedef logic [LINE_BITS-1:0]         line_t;

    // outside channels
    typedef struct packed {
        logic       wr;
        line_addr_t addr;
        line_t      data;
    } llc_req_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } llc_rsp_t;

    typedef struct packed {
        logic       wr;
        line_addr_t addr;
        line_t      data;
    } llc_mem_req_t;

    // one way of one set
    typedef struct packed {
        logic     valid;
        logic     dirty;
        llc_tag_t tag;
        line_t    line;
    } llc_entry_t;

    // stage packets
    typedef struct packed {
        llc_req_t req;
        llc_set_t set;
        llc_tag_t tag;
    } llc_decoded_t;

    typedef struct packed {
        llc_decoded_t                  dec;
        llc_entry_t [LLC_WAYS-1:0]     entries;
        llc_way_t                      evict_way;
    } llc_read_pkt_t;

    typedef struct packed {
        llc_decoded_t dec;
        logic         hit;
        llc_way_t     way;
        llc_entry_t   entry;
        llc_way_t     next_evict_way;
    } llc_lookup_pkt_t;

    typedef struct packed {
        logic       en;
        llc_set_t   set;
        llc_way_t   way;
        llc_entry_t entry;
        llc_way_t   evict_way;
    } llc_wr_t;

endpackage
